/* verif/csr_trace.txt */
# Hex fields: W addr mask data | R addr expected | X ecode pc | E expected new_pc
# H hw_int | I expected has_int | N idle cycles | C cycles expected counter delta
R 0000 00000008
W 0004 000000f0 ffffffff
W 0004 00000c0f 0000ffff
R 0004 000008ff
W 000c ffffffff 1c0080ff
R 000c 1c0080c0
W 0030 ffffffff 11111111
W 0031 ffffffff 2222aaaa
W 0032 ffffffff 3333bbbb
W 0033 ffffffff 4444cccc
W 0040 ffffffff 0000abcd
R 0030 11111111
R 0031 2222aaaa
R 0032 3333bbbb
R 0033 4444cccc
R 0040 0000abcd
R 0044 00000000
# Exception entry and return
W 0000 ffffffff 00000007
X 0b 1c000100
R 0001 00000007
R 0000 00000000
R 0006 1c000100
R 0005 000b0000
E 1c000104
R 0000 00000007
X 01 1c000200
E 1c000200
# Hardware interrupt
H 40
R 0005 00010100
I 0
W 0004 00000100 00000100
I 1
W 0000 00000004 00000000
I 0
H 00
# One-shot timer, then clear
W 0041 ffffffff 00000009
N 8
R 0005 00010000
R 0005 00010800
R 0042 ffffffff
W 0044 ffffffff 00000001
R 0005 00010000
N a
R 0005 00010000
# Stable counter and CNTC offset
C 10 0000000000000010
W 0043 ffffffff ffffffff
C 8 0000000000000007

/* loongarch_csr.f */
logic/csr_pkg.sv
logic/csr_except_unit.sv
logic/csr_timer.sv
logic/csr_scratch.sv
logic/csr_read_mux.sv
logic/loongarch_csr.sv
verif/tb_loongarch_csr.sv

/* Bender.yml */
package:
  name: loongarch_csr

sources:
  - logic/csr_pkg.sv
  - logic/csr_except_unit.sv
  - logic/csr_timer.sv
  - logic/csr_scratch.sv
  - logic/csr_read_mux.sv
  - logic/loongarch_csr.sv
  - target: test
    files:
      - verif/tb_loongarch_csr.sv

/* verif/tb_loongarch_csr.sv */
`timescale 1ns/10ps

module tb_loongarch_csr;
    import csr_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam TRACE_FILE = "verif/csr_trace.txt";

    logic        clk;
    logic        rstn;
    csr_addr_t   raddr;
    csr_wr_t     wr;
    exc_req_t    exc;
    logic        ertn_flush;
    logic [7:0]  hw_int;
    csr_data_t   rdata;
    logic        has_int;
    csr_data_t   new_pc;
    csr_data_t   ex_entry_pc;
    logic [63:0] counter;

    logic [63:0] fld [3];  // hex fields of the current trace line
    int          fd;
    int          total;
    int          cycle_count;
    int          cycle_limit;
    logic        limit_ready;
    logic [7:0]  cmd;
    bit          found;

    loongarch_csr #(.N_SAVE(4)) u_loongarch_csr (
        .clk         (clk),
        .rstn        (rstn),
        .raddr       (raddr),
        .wr          (wr),
        .exc         (exc),
        .ertn_flush  (ertn_flush),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .has_int     (has_int),
        .new_pc      (new_pc),
        .ex_entry_pc (ex_entry_pc),
        .counter     (counter)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t got);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s exp 0x%h got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s exp 0x%h got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_counter(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s exp 0x%h got 0x%h", name, exp, got));
        end
    endtask

    function automatic int field_count(input logic [7:0] c);
        case (c)
            "W": return 3;
            "R", "X", "C": return 2;
            "E", "H", "I", "N": return 1;
            default: return -1;
        endcase
    endfunction

    function automatic int command_cycles(input logic [7:0] c, input logic [63:0] n);
        if (c == "N" || c == "C") begin
            return int'(n);
        end
        return 1;
    endfunction

    // Skips comment lines, found stays 0 at end of file
    task automatic next_command(input int f, output logic [7:0] c, output bit ok);
        logic [8*256-1:0] rest;
        int code;
        bit at_end;
        ok = 1'b0;
        at_end = 1'b0;
        c = 8'h00;
        while (!ok && !at_end) begin
            code = $fscanf(f, " %c", c);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (c == "#") begin
                code = $fgets(rest, f);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic read_fields(input int f, input logic [7:0] c);
        logic [63:0] val;
        int nf;
        nf = field_count(c);
        if (nf < 0) begin
            abort_run($sformatf("unknown command '%c' in the trace file", c));
        end
        for (int i = 0; i < nf; i++) begin
            if ($fscanf(f, "%h", val) != 1) begin
                abort_run($sformatf("trace command '%c' is missing a field", c));
            end
            fld[i] = val;
        end
    endtask

    // Next edge plus drive delay, strobes back to idle
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        wr         = '0;
        exc        = '0;
        ertn_flush = 1'b0;
    endtask

    task automatic run_command(input logic [7:0] c);
        logic [63:0] start_count;
        case (c)
            "W": begin
                advance_cycle();
                wr.en   = 1'b1;
                wr.addr = fld[0][13:0];
                wr.mask = fld[1][31:0];
                wr.data = fld[2][31:0];
            end
            "R": begin
                advance_cycle();
                raddr = fld[0][13:0];
                #2;
                check_data($sformatf("rdata at 0x%h", raddr), fld[1][31:0], rdata);
                if (fld[0][13:0] == CSR_EENTRY) begin
                    check_data("ex_entry_pc", fld[1][31:0], ex_entry_pc);  // same as EENTRY
                end
            end
            "X": begin
                advance_cycle();
                exc.ex_en    = 1'b1;
                exc.ecode    = fld[0][7:0];
                exc.esubcode = 1'b0;
                exc.pc       = fld[1][31:0];
            end
            "E": begin
                advance_cycle();
                ertn_flush = 1'b1;
                #2;
                check_data("new_pc", fld[0][31:0], new_pc);  // still before the return
            end
            "H": begin
                advance_cycle();
                hw_int = fld[0][7:0];
            end
            "I": begin
                advance_cycle();
                #2;
                check_bit("has_int", fld[0][0], has_int);
            end
            "N": begin
                repeat (int'(fld[0])) advance_cycle();
            end
            default: begin
                // Start sample taken in the previous command's cycle
                start_count = counter;
                repeat (int'(fld[0])) advance_cycle();
                #2;
                check_counter("counter delta", fld[1], counter - start_count);
            end
        endcase
    endtask

    always @(posedge clk) begin
        if (limit_ready) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                abort_run("simulation hung: the trace did not finish within the cycle limit");
            end
        end
    end

    initial begin
        rstn        = 1'b0;
        raddr       = '0;
        wr          = '0;
        exc         = '0;
        ertn_flush  = 1'b0;
        hw_int      = 8'h00;
        cycle_count = 0;
        cycle_limit = 0;
        limit_ready = 1'b0;

        // First pass sizes the timeout
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file verif/csr_trace.txt");
        end
        total = 0;
        next_command(fd, cmd, found);
        while (found) begin
            read_fields(fd, cmd);
            total = total + command_cycles(cmd, fld[0]);
            next_command(fd, cmd, found);
        end
        $fclose(fd);
        cycle_limit = RESET_CYCLES + total + 100;
        limit_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;

        fd = $fopen(TRACE_FILE, "r");
        next_command(fd, cmd, found);
        while (found) begin
            read_fields(fd, cmd);
            run_command(cmd);
            next_command(fd, cmd, found);
        end
        $fclose(fd);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* logic/loongarch_csr.sv */
`timescale 1ns/10ps

module loongarch_csr #(
    parameter int N_SAVE = 4
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  csr_pkg::csr_addr_t          raddr,
    input  csr_pkg::csr_wr_t            wr,
    input  csr_pkg::exc_req_t           exc,
    input  logic                        ertn_flush,
    input  logic [7:0]                  hw_int,
    output csr_pkg::csr_data_t          rdata,
    output logic                        has_int,
    output csr_pkg::csr_data_t          new_pc,
    output csr_pkg::csr_data_t          ex_entry_pc,
    output logic [63:0]                 counter
);
    import csr_pkg::*;

    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t ecfg;
    csr_data_t estat;
    csr_data_t era;
    csr_data_t eentry;
    csr_data_t tcfg;
    csr_data_t tval;
    csr_data_t cntc;
    csr_data_t tid;
    csr_data_t [N_SAVE-1:0] save_q;
    logic      timer_int;

    csr_except_unit u_except (
        .clk         (clk),
        .rstn        (rstn),
        .wr          (wr),
        .exc         (exc),
        .ertn_flush  (ertn_flush),
        .hw_int      (hw_int),
        .timer_int   (timer_int),
        .crmd        (crmd),
        .prmd        (prmd),
        .ecfg        (ecfg),
        .estat       (estat),
        .era         (era),
        .eentry      (eentry),
        .has_int     (has_int),
        .new_pc      (new_pc),
        .ex_entry_pc (ex_entry_pc)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .cntc      (cntc),
        .timer_int (timer_int),
        .counter   (counter)
    );

    csr_scratch #(.N_SAVE(N_SAVE)) u_scratch (
        .clk    (clk),
        .rstn   (rstn),
        .wr     (wr),
        .save_q (save_q),
        .tid    (tid)
    );

    csr_read_mux #(.N_SAVE(N_SAVE)) u_read_mux (
        .raddr  (raddr),
        .crmd   (crmd),
        .prmd   (prmd),
        .ecfg   (ecfg),
        .estat  (estat),
        .era    (era),
        .eentry (eentry),
        .save_q (save_q),
        .tid    (tid),
        .tcfg   (tcfg),
        .tval   (tval),
        .cntc   (cntc),
        .rdata  (rdata)
    );

endmodule

/* logic/csr_read_mux.sv */
`timescale 1ns/10ps

module csr_read_mux #(
    parameter int N_SAVE = 4
) (
    input  csr_pkg::csr_addr_t              raddr,
    input  csr_pkg::csr_data_t              crmd,
    input  csr_pkg::csr_data_t              prmd,
    input  csr_pkg::csr_data_t              ecfg,
    input  csr_pkg::csr_data_t              estat,
    input  csr_pkg::csr_data_t              era,
    input  csr_pkg::csr_data_t              eentry,
    input  csr_pkg::csr_data_t [N_SAVE-1:0] save_q,
    input  csr_pkg::csr_data_t              tid,
    input  csr_pkg::csr_data_t              tcfg,
    input  csr_pkg::csr_data_t              tval,
    input  csr_pkg::csr_data_t              cntc,
    output csr_pkg::csr_data_t              rdata
);
    import csr_pkg::*;

    always_comb begin
        rdata = '0;
        case (raddr)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg;
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era;
            CSR_EENTRY: rdata = eentry;
            CSR_TID:    rdata = tid;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            CSR_CNTC:   rdata = cntc;
            CSR_TICLR:  rdata = '0;  // write-only clear
            default: begin
                // SAVE bank occupies CSR_SAVE0 onward
                for (int i = 0; i < N_SAVE; i++) begin
                    if (raddr == CSR_SAVE0 + csr_addr_t'(i)) begin
                        rdata = save_q[i];
                    end
                end
            end
        endcase
    end

endmodule

/* logic/csr_scratch.sv */
`timescale 1ns/10ps

module csr_scratch #(
    parameter int N_SAVE = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  csr_pkg::csr_wr_t                wr,
    output csr_pkg::csr_data_t [N_SAVE-1:0] save_q,
    output csr_pkg::csr_data_t              tid
);
    import csr_pkg::*;

    for (genvar i = 0; i < N_SAVE; i++) begin : g_save
        // No reset, contents undefined until software writes them
        always_ff @(posedge clk) begin
            if (csr_hit(wr, CSR_SAVE0 + csr_addr_t'(i))) begin
                save_q[i] <= csr_merge(save_q[i], wr, FULL_WMASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tid <= '0;
        end else if (csr_hit(wr, CSR_TID)) begin
            tid <= csr_merge(tid, wr, FULL_WMASK);
        end
    end

endmodule

/* logic/csr_timer.sv */
`timescale 1ns/10ps

module csr_timer (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   wr,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output csr_pkg::csr_data_t cntc,
    output logic               timer_int,
    output logic [63:0]        counter
);
    import csr_pkg::*;

    logic      timer_en;
    logic      tcfg_we;
    logic      expire;
    logic      ticlr_clr;
    csr_data_t tcfg_next;
    logic [63:0] stable_cnt;

    assign tcfg_we   = csr_hit(wr, CSR_TCFG);
    assign tcfg_next = csr_merge(tcfg, wr, FULL_WMASK);
    assign expire    = timer_en && (tval == '0);
    assign ticlr_clr = csr_hit(wr, CSR_TICLR) && wr.data[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg <= '0;
        end else if (tcfg_we) begin
            tcfg <= tcfg_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_en <= 1'b0;
        end else if (tcfg_we) begin
            timer_en <= wr.data[TCFG_EN_BIT];
        end else if (expire) begin
            timer_en <= tcfg[TCFG_PERIODIC_BIT];  // one-shot stops here
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval <= '0;
        end else if (tcfg_we) begin
            tval <= {tcfg_next[31:2], 2'b00};
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 32'd1;
            end else if (tcfg[TCFG_PERIODIC_BIT]) begin
                tval <= {tcfg[31:2], 2'b00};
            end else begin
                tval <= 32'hFFFF_FFFF;
            end
        end
    end

    // Clear wins over a new expiry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_int <= 1'b0;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end else if (expire) begin
            timer_int <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cntc <= '0;
        end else if (csr_hit(wr, CSR_CNTC)) begin
            cntc <= csr_merge(cntc, wr, FULL_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    assign counter = stable_cnt + {{32{cntc[31]}}, cntc};  // signed offset

endmodule

/* logic/csr_except_unit.sv */
`timescale 1ns/10ps

module csr_except_unit (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   wr,
    input  csr_pkg::exc_req_t  exc,
    input  logic               ertn_flush,
    input  logic [7:0]         hw_int,
    input  logic               timer_int,
    output csr_pkg::csr_data_t crmd,
    output csr_pkg::csr_data_t prmd,
    output csr_pkg::csr_data_t ecfg,
    output csr_pkg::csr_data_t estat,
    output csr_pkg::csr_data_t era,
    output csr_pkg::csr_data_t eentry,
    output logic               has_int,
    output csr_pkg::csr_data_t new_pc,
    output csr_pkg::csr_data_t ex_entry_pc
);
    import csr_pkg::*;

    csr_data_t estat_q;   // everything but the timer bit
    csr_data_t estat_wval;
    logic      in_ex;
    logic [ESTAT_ECODE_W-1:0] cur_ecode;
    logic      ret_next;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd <= CRMD_RESET;
        end else if (exc.ex_en) begin
            crmd[1:0]         <= 2'b00;
            crmd[CRMD_IE_BIT] <= 1'b0;
        end else if (ertn_flush) begin
            crmd[1:0]         <= prmd[1:0];
            crmd[CRMD_IE_BIT] <= prmd[PRMD_PIE_BIT];
        end else if (csr_hit(wr, CSR_CRMD)) begin
            crmd <= csr_merge(crmd, wr, CRMD_WMASK);
        end
    end

    // Ertn leaves PRMD alone but still blocks a write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd <= '0;
        end else if (exc.ex_en) begin
            prmd[1:0]          <= crmd[1:0];
            prmd[PRMD_PIE_BIT] <= crmd[CRMD_IE_BIT];
        end else if (csr_hit(wr, CSR_PRMD) && !ertn_flush) begin
            prmd <= csr_merge(prmd, wr, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg <= '0;
        end else if (csr_hit(wr, CSR_ECFG)) begin
            ecfg <= csr_merge(ecfg, wr, ECFG_WMASK);
        end
    end

    assign estat_wval = csr_merge(estat_q, wr, ESTAT_WMASK);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            estat_q <= '0;
        end else begin
            estat_q[9:2] <= hw_int;  // sampled every cycle
            if (exc.ex_en) begin
                estat_q[ESTAT_ECODE_LSB +: ESTAT_ECODE_W] <= exc.ecode[ESTAT_ECODE_W-1:0];
                estat_q[ESTAT_ESUBCODE_LSB +: ESTAT_ESUBCODE_W] <=
                    {{(ESTAT_ESUBCODE_W-1){1'b0}}, exc.esubcode};
            end else if (csr_hit(wr, CSR_ESTAT)) begin
                estat_q[1:0] <= estat_wval[1:0];
            end
        end
    end

    assign estat = estat_q | (csr_data_t'(timer_int) << TIMER_IS_BIT);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era <= '0;
        end else if (exc.ex_en) begin
            era <= exc.pc;
        end else if (csr_hit(wr, CSR_ERA)) begin
            era <= csr_merge(era, wr, FULL_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry <= '0;
        end else if (csr_hit(wr, CSR_EENTRY)) begin
            eentry <= csr_merge(eentry, wr, EENTRY_WMASK);
        end
    end

    // Tracks whether ERA was loaded by an exception
    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_ex <= 1'b0;
        end else if (exc.ex_en) begin
            in_ex <= 1'b1;
        end else if (ertn_flush) begin
            in_ex <= 1'b0;
        end
    end

    assign cur_ecode = estat_q[ESTAT_ECODE_LSB +: ESTAT_ECODE_W];

    // These codes return past the trapping instruction
    assign ret_next = ({2'b00, cur_ecode} == ECODE_INT) ||
                      ({2'b00, cur_ecode} == ECODE_SYS) ||
                      ({2'b00, cur_ecode} == ECODE_BRK) ||
                      ({2'b00, cur_ecode} == ECODE_INE);

    assign new_pc      = (in_ex && ret_next) ? era + 32'd4 : era;
    assign ex_entry_pc = eentry;
    assign has_int     = crmd[CRMD_IE_BIT] & (|(ecfg[12:0] & estat[12:0]));

endmodule

/* logic/csr_pkg.sv */
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // One write port command
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t mask;
        csr_data_t data;
    } csr_wr_t;

    // Exception request from the pipeline
    typedef struct packed {
        logic      ex_en;
        logic [7:0] ecode;
        logic      esubcode;
        csr_data_t pc;
    } exc_req_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h00;
    localparam csr_addr_t CSR_PRMD   = 14'h01;
    localparam csr_addr_t CSR_ECFG   = 14'h04;
    localparam csr_addr_t CSR_ESTAT  = 14'h05;
    localparam csr_addr_t CSR_ERA    = 14'h06;
    localparam csr_addr_t CSR_EENTRY = 14'h0C;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;  // SAVE bank base
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_CNTC   = 14'h43;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // Exception codes
    localparam logic [7:0] ECODE_INT = 8'h00;
    localparam logic [7:0] ECODE_SYS = 8'h0B;
    localparam logic [7:0] ECODE_BRK = 8'h0C;
    localparam logic [7:0] ECODE_INE = 8'h0D;

    // Field positions
    localparam int CRMD_IE_BIT        = 2;   // PLV sits in 1:0
    localparam int PRMD_PIE_BIT       = 2;   // PPLV sits in 1:0
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ECODE_W      = 6;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int ESTAT_ESUBCODE_W   = 9;
    localparam int TIMER_IS_BIT       = 11;
    localparam int TCFG_EN_BIT        = 0;
    localparam int TCFG_PERIODIC_BIT  = 1;
    localparam int TICLR_CLR_BIT      = 0;

    localparam csr_data_t CRMD_RESET = 32'h0000_0008;  // DA set

    // Software writable bits per register
    localparam csr_data_t CRMD_WMASK   = 32'h0000_01FF;
    localparam csr_data_t PRMD_WMASK   = 32'h0000_0007;
    localparam csr_data_t ECFG_WMASK   = 32'h0000_1BFF;
    localparam csr_data_t ESTAT_WMASK  = 32'h0000_0003;
    localparam csr_data_t EENTRY_WMASK = 32'hFFFF_FFC0;
    localparam csr_data_t FULL_WMASK   = 32'hFFFF_FFFF;

    // New value after a masked write, limited to the writable field bits
    function automatic csr_data_t csr_merge(
        csr_data_t old_val,
        csr_wr_t   w,
        csr_data_t field_mask
    );
        csr_data_t sel;
        sel = w.mask & field_mask;
        return (w.data & sel) | (old_val & ~sel);
    endfunction

    function automatic logic csr_hit(csr_wr_t w, csr_addr_t addr);
        return w.en && (w.addr == addr);
    endfunction

endpackage
